// ==== common/vic_board_macros.svh ====
`ifndef VIC_BOARD_MACROS_SVH
`define VIC_BOARD_MACROS_SVH

// sys_clock cycles per serial bit, kept small for simulation
`define VB_CLKS_PER_BIT 8

// sys_clock cycles per half period of clk_phi
// full phi period is twice this, 32 sys_clock cycles
`define VB_PHI_DIV 16

// transmit queue entries, also the controller's credits after reset
// must stay a power of two for the queue pointers
`define VB_TX_DEPTH 4

// reply bytes
`define VB_REPLY_ACK 8'hA5
`define VB_REPLY_NAK 8'h5A

// answer to cmd_get_version
`define VB_VERSION 8'h31

`endif

// ==== common/vic_board_pkg.sv ====
`default_nettype none

// shared types for the board config link
package vic_board_pkg;

   // command opcodes sent by the mcu, one byte each
   typedef enum logic [7:0] {
      cmd_get_chip    = 8'h01,  // reply is the chip register
      cmd_set_chip    = 8'h02,  // data byte follows, low two bits used
      cmd_cpu_reset   = 8'h03,  // data byte follows, bit 0 used
      cmd_get_version = 8'h04   // reply is the version byte
   } cmd_opcode_t;

   // command decoder states
   typedef enum logic [1:0] {
      idle     = 2'd0,  // waiting for an opcode
      wait_arg = 2'd1,  // opcode needs a data byte
      reply    = 2'd2   // reply formed, waiting for a credit
   } ctrl_state_t;

   // one byte moving between blocks
   // valid is a single-cycle strobe, data is only meaningful with it
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } serial_byte_t;

endpackage : vic_board_pkg

`default_nettype wire

// ==== design/config_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "vic_board_macros.svh"

// command decoder for the mcu link
// every command gets exactly one reply byte.
// set commands wait for their data byte, then update chip or cpu_reset.
// replies are only sent while a transmit credit is held
module config_ctrl import vic_board_pkg::*; (
   input  logic         sys_clock,
   input  logic         reset,
   input  serial_byte_t rx_byte,    // received bytes without back-pressure
   input  logic         tx_credit,  // a queue slot came free
   output serial_byte_t tx_req,     // reply bytes to the transmitter
   output logic [1:0]   chip,       // chip model select
   output logic         cpu_reset   // high holds the cpu in reset
);

   localparam int CRD_W = $clog2(`VB_TX_DEPTH + 1);
   localparam logic [CRD_W-1:0] CRD_MAX = CRD_W'(`VB_TX_DEPTH);

   ctrl_state_t      state_q;
   ctrl_state_t      state_d;
   cmd_opcode_t      opcode_q;   // opcode waiting for its data byte
   cmd_opcode_t      opcode_d;
   logic [7:0]       reply_q;    // reply held while out of credits
   logic [7:0]       reply_d;
   logic [1:0]       chip_q;
   logic [1:0]       chip_d;
   logic             cpu_reset_q;
   logic             cpu_reset_d;
   logic [CRD_W-1:0] credits_q;  // free queue slots in serial_tx
   logic             send;       // reply goes out this cycle
   logic             tx_valid_q;
   logic [7:0]       tx_data_q;

   always_comb begin
      state_d     = state_q;
      opcode_d    = opcode_q;
      reply_d     = reply_q;
      chip_d      = chip_q;
      cpu_reset_d = cpu_reset_q;
      send        = 1'b0;

      case (state_q)
         idle: begin
            if (rx_byte.valid) begin
               opcode_d = cmd_opcode_t'(rx_byte.data);
               state_d  = reply;  // most opcodes answer at once
               case (opcode_d)
                  cmd_get_chip:    reply_d = {6'b0, chip_q};
                  cmd_set_chip:    state_d = wait_arg;
                  cmd_cpu_reset:   state_d = wait_arg;
                  cmd_get_version: reply_d = `VB_VERSION;
                  default:         reply_d = `VB_REPLY_NAK;  // unknown opcode
               endcase
            end
         end
         wait_arg: begin
            if (rx_byte.valid) begin
               if (opcode_q == cmd_set_chip)
                  chip_d = rx_byte.data[1:0];
               else
                  cpu_reset_d = rx_byte.data[0];
               reply_d = `VB_REPLY_ACK;
               state_d = reply;
            end
         end
         reply: begin
            // incoming bytes are ignored while stalled on credits
         end
         default: state_d = idle;
      endcase

      // reply leaves the cycle it is formed if a slot is free
      if (state_d == reply && credits_q != '0) begin
         send    = 1'b1;
         state_d = idle;
      end
   end

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         state_q     <= idle;
         chip_q      <= 2'b00;
         cpu_reset_q <= 1'b1;  // cpu held until the mcu releases it
         tx_valid_q  <= 1'b0;
      end else begin
         state_q     <= state_d;
         chip_q      <= chip_d;
         cpu_reset_q <= cpu_reset_d;
         tx_valid_q  <= send;
      end
   end

   // latched opcode, pending reply and the byte handed to the transmitter
   always_ff @(posedge sys_clock) begin
      opcode_q <= opcode_d;
      reply_q  <= reply_d;
      if (send)
         tx_data_q <= reply_d;
   end

   // credit counter from 0 to VB_TX_DEPTH
   always_ff @(posedge sys_clock) begin
      if (reset) begin
         credits_q <= CRD_MAX;
      end else begin
         case ({tx_credit, send})
            2'b10:   credits_q <= credits_q + 1'b1;
            2'b01:   credits_q <= credits_q - 1'b1;
            default: credits_q <= credits_q;  // none or both
         endcase
      end
   end

   assign tx_req    = '{valid: tx_valid_q, data: tx_data_q};
   assign chip      = chip_q;
   assign cpu_reset = cpu_reset_q;

endmodule : config_ctrl

`default_nettype wire

// ==== design/phi_gen.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "vic_board_macros.svh"

// cpu phi clock from sys_clock
// phi toggles every VB_PHI_DIV cycles, so it runs at sys_clock / 32
module phi_gen (
   input  logic sys_clock,
   input  logic reset,
   output logic clk_phi   // low during reset
);

   localparam int DIV_W = $clog2(`VB_PHI_DIV);
   localparam logic [DIV_W-1:0] DIV_RELOAD = DIV_W'(`VB_PHI_DIV - 1);

   logic [DIV_W-1:0] div_cnt;  // counts down to the next phi edge
   logic             phi_q;

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         div_cnt <= DIV_RELOAD;
         phi_q   <= 1'b0;
      end else if (div_cnt == '0) begin
         div_cnt <= DIV_RELOAD;
         phi_q   <= ~phi_q;  // half period done
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

   assign clk_phi = phi_q;

endmodule : phi_gen

`default_nettype wire

// ==== design/vic_board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// board side of the mcu config link
// everything runs on sys_clock
module vic_board_top import vic_board_pkg::*; (
   input  logic       sys_clock,
   input  logic       reset,
   input  logic       rx,         // commands from mcu
   input  logic       mcu_ready,  // mcu can accept reply bytes
   output logic       tx,         // replies to mcu
   output logic [1:0] chip,       // chip model
   output logic       cpu_reset,  // 6510 reset, active high
   output logic       clk_phi     // cpu phi clock
);

   serial_byte_t rx_byte;    // receiver to decoder
   serial_byte_t tx_req;     // decoder to transmitter
   logic         tx_credit;  // transmitter back to decoder

   serial_rx serial_rx_inst (
      .sys_clock (sys_clock),
      .reset     (reset),
      .rx        (rx),
      .rx_byte   (rx_byte)
   );

   config_ctrl config_ctrl_inst (
      .sys_clock (sys_clock),
      .reset     (reset),
      .rx_byte   (rx_byte),
      .tx_credit (tx_credit),
      .tx_req    (tx_req),
      .chip      (chip),
      .cpu_reset (cpu_reset)
   );

   serial_tx serial_tx_inst (
      .sys_clock (sys_clock),
      .reset     (reset),
      .tx_req    (tx_req),
      .mcu_ready (mcu_ready),
      .tx_credit (tx_credit),
      .tx        (tx)
   );

   // phi runs free, independent of the link
   phi_gen phi_gen_inst (
      .sys_clock (sys_clock),
      .reset     (reset),
      .clk_phi   (clk_phi)
   );

endmodule : vic_board_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vic board testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
   --top-module tb_vic_board_top \
   -f vic_board_top.f \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi

// ==== serial/serial_rx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "vic_board_macros.svh"

// 8n1 receiver for the command line from the mcu
// the line is sampled near mid-bit, frames with a bad stop bit are dropped
module serial_rx import vic_board_pkg::*; (
   input  logic         sys_clock,
   input  logic         reset,
   input  logic         rx,       // from mcu, idles high
   output serial_byte_t rx_byte   // valid for one cycle per good frame
);

   localparam int CNT_W = $clog2(`VB_CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_RELOAD = CNT_W'(`VB_CLKS_PER_BIT - 1);
   // first wait is half a bit, two cycles short to make up for the synchronizer
   localparam logic [CNT_W-1:0] HALF_RELOAD = CNT_W'(`VB_CLKS_PER_BIT / 2 - 2);

   logic             rx_meta;
   logic             rx_sync;
   logic             busy;      // inside a frame
   logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9 stop
   logic [CNT_W-1:0] clk_cnt;   // cycles left to the next sample
   logic [7:0]       shift_q;   // data bits, lsb arrives first
   logic             valid_q;
   logic             sample;

   assign sample = busy && (clk_cnt == '0);

   // two-flop synchronizer, line idles high
   always_ff @(posedge sys_clock) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         busy    <= 1'b0;
         bit_cnt <= '0;
         clk_cnt <= '0;
         valid_q <= 1'b0;
      end else begin
         valid_q <= 1'b0;  // strobe by default low
         if (!busy) begin
            if (!rx_sync) begin  // start edge
               busy    <= 1'b1;
               bit_cnt <= '0;
               clk_cnt <= HALF_RELOAD;
            end
         end else if (!sample) begin
            clk_cnt <= clk_cnt - 1'b1;
         end else begin
            clk_cnt <= BIT_RELOAD;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd0 && rx_sync) begin
               busy <= 1'b0;  // start bit gone by mid-bit, just a glitch
            end else if (bit_cnt == 4'd9) begin
               busy    <= 1'b0;
               valid_q <= rx_sync;  // stop bit must be 1
            end
         end
      end
   end

   always_ff @(posedge sys_clock) begin
      if (sample && bit_cnt inside {[4'd1:4'd8]})
         shift_q <= {rx_sync, shift_q[7:1]};
   end

   assign rx_byte = '{valid: valid_q, data: shift_q};

endmodule : serial_rx

`default_nettype wire

// ==== serial/serial_tx.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "vic_board_macros.svh"

// reply transmitter
// replies land in a small circular queue, the head goes into an 8n1 shifter
// whenever the shifter is free and the mcu says it is ready.
// every dequeue hands one credit back to the controller, so the queue
// never takes more bytes than it has room for
module serial_tx import vic_board_pkg::*; (
   input  logic         sys_clock,
   input  logic         reset,
   input  serial_byte_t tx_req,     // reply bytes from the controller
   input  logic         mcu_ready,  // async from mcu, high when it can take data
   output logic         tx_credit,  // one pulse per dequeued byte
   output logic         tx          // to mcu, idles high
);

   localparam int PTR_W = $clog2(`VB_TX_DEPTH);
   localparam int CNT_W = $clog2(`VB_CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] BIT_RELOAD = CNT_W'(`VB_CLKS_PER_BIT - 1);

   logic [7:0]       queue_mem [`VB_TX_DEPTH];
   logic [PTR_W:0]   wr_ptr;       // extra msb tells full from empty
   logic [PTR_W:0]   rd_ptr;
   logic             queue_empty;
   logic             ready_meta;
   logic             ready_sync;
   logic             busy;         // frame on the line
   logic [3:0]       bit_cnt;      // bits already sent in this frame
   logic [CNT_W-1:0] clk_cnt;
   logic [9:0]       shift_q;      // stop, data, start, lsb goes out first
   logic             dequeue;

   assign queue_empty = (wr_ptr == rd_ptr);
   assign dequeue     = !queue_empty && !busy && ready_sync;

   // mcu_ready comes from the mcu clock domain
   always_ff @(posedge sys_clock) begin
      if (reset) begin
         ready_meta <= 1'b0;
         ready_sync <= 1'b0;
      end else begin
         ready_meta <= mcu_ready;
         ready_sync <= ready_meta;
      end
   end

   // queue storage
   always_ff @(posedge sys_clock) begin
      if (tx_req.valid)
         queue_mem[wr_ptr[PTR_W-1:0]] <= tx_req.data;
   end

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (tx_req.valid)
            wr_ptr <= wr_ptr + 1'b1;  // credits guarantee room
         if (dequeue)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // shifter
   always_ff @(posedge sys_clock) begin
      if (reset) begin
         busy      <= 1'b0;
         bit_cnt   <= '0;
         clk_cnt   <= '0;
         shift_q   <= '1;    // line idle
         tx_credit <= 1'b0;
      end else begin
         tx_credit <= dequeue;
         if (dequeue) begin
            shift_q <= {1'b1, queue_mem[rd_ptr[PTR_W-1:0]], 1'b0};
            busy    <= 1'b1;
            bit_cnt <= '0;
            clk_cnt <= BIT_RELOAD;
         end else if (busy) begin
            if (clk_cnt != '0) begin
               clk_cnt <= clk_cnt - 1'b1;
            end else begin
               clk_cnt <= BIT_RELOAD;
               shift_q <= {1'b1, shift_q[9:1]};  // refill with idle ones
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd9)
                  busy <= 1'b0;  // stop bit done
            end
         end
      end
   end

   assign tx = shift_q[0];  // straight from a flop, no glitches

endmodule : serial_tx

`default_nettype wire

// ==== test/tb_vic_board_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "vic_board_macros.svh"

// testbench for the mcu config link
// commands go out on rx and replies decoded from tx are compared with the table
module tb_vic_board_top
   import vic_board_pkg::*;
();

   localparam int NUM_CMDS      = 10;
   localparam int START_TIMEOUT = 60 * `VB_CLKS_PER_BIT;  // cycles to wait for a start bit
   localparam int PHI_TIMEOUT   = 4 * `VB_PHI_DIV;

   // one command with its expected results
   typedef struct packed {
      logic [7:0] opcode;
      logic [7:0] data;
      logic       has_data;       // send the data byte after the opcode
      logic [7:0] exp_reply;
      logic [1:0] exp_chip;
      logic       exp_cpu_reset;
   } cmd_entry_t;

   logic       sys_clock = 1'b0;
   logic       reset;
   logic       rx;
   logic       mcu_ready;
   logic       tx;
   logic [1:0] chip;
   logic       cpu_reset;
   logic       clk_phi;

   cmd_entry_t cmd_tbl [NUM_CMDS];
   integer     seed;
   int         error_count = 0;
   int         test_count  = 0;
   int         fail_count  = 0;
   logic       sent_done;  // back-pressure sender finished

   vic_board_top vic_board_top_inst (
      .sys_clock (sys_clock),
      .reset     (reset),
      .rx        (rx),
      .mcu_ready (mcu_ready),
      .tx        (tx),
      .chip      (chip),
      .cpu_reset (cpu_reset),
      .clk_phi   (clk_phi)
   );

   always #20 sys_clock = ~sys_clock;  // 40 ns period

   // all driving and sampling happens 2 ns after the rising edge
   task automatic next_cycle();
      @(posedge sys_clock);
      #2;
   endtask

   // one 8n1 frame on rx with the lsb first
   task automatic send_byte(input logic [7:0] value);
      logic [9:0] frame;
      int         b;
      frame = {1'b1, value, 1'b0};
      for (b = 0; b < 10; b++) begin
         rx = frame[b];
         repeat (`VB_CLKS_PER_BIT) next_cycle();
      end
   endtask

   // decode one frame from tx by sampling at mid-bit
   task automatic recv_byte(output logic [7:0] value, output logic ok);
      logic [9:0] frame;
      int         wait_cnt;
      int         b;
      ok       = 1'b1;
      value    = 8'h00;
      frame    = '1;
      wait_cnt = 0;
      while (tx !== 1'b0 && wait_cnt < START_TIMEOUT) begin
         next_cycle();
         wait_cnt++;
      end
      if (tx !== 1'b0) begin
         $display("timeout while waiting for a start bit on tx");
         error_count++;
         ok = 1'b0;
      end else begin
         repeat (`VB_CLKS_PER_BIT / 2) next_cycle();  // to the middle of the start bit
         for (b = 0; b < 10; b++) begin
            frame[b] = tx;
            if (b < 9)
               repeat (`VB_CLKS_PER_BIT) next_cycle();
         end
         value = frame[8:1];
         if (frame[0] !== 1'b0 || frame[9] !== 1'b1) begin
            $display("reply frame on tx has a bad start or stop bit");
            error_count++;
            ok = 1'b0;
         end
      end
   endtask

   // first phi edge comes VB_PHI_DIV cycles after reset release and every VB_PHI_DIV after
   task automatic check_phi();
      int   cnt;
      int   half;
      logic level;
      cnt = 0;
      while (clk_phi !== 1'b1 && cnt < PHI_TIMEOUT) begin
         next_cycle();
         cnt++;
      end
      if (clk_phi !== 1'b1) begin
         $display("timeout while waiting for clk_phi to rise after reset");
         error_count++;
      end else begin
         if (cnt != `VB_PHI_DIV) begin
            $display("[ERROR] clk_phi first edge: got %0h expected %0h", cnt, `VB_PHI_DIV);
            error_count++;
         end
         for (half = 0; half < 2; half++) begin  // one high and one low half
            level = clk_phi;
            cnt   = 0;
            while (clk_phi === level && cnt < PHI_TIMEOUT) begin
               next_cycle();
               cnt++;
            end
            if (cnt != `VB_PHI_DIV) begin
               $display("[ERROR] clk_phi half period: got %0h expected %0h",
                        cnt, `VB_PHI_DIV);
               error_count++;
            end
         end
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_count++;
      if (error_count == errs_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         fail_count++;
         $display("test %0d %s: FAIL", test_count, name);
      end
   endtask

   initial begin
      logic [31:0] rnd_a;
      logic [31:0] rnd_b;
      logic [7:0]  got;
      logic        ok;
      int          errs_before;
      int          low_cnt;
      int          i;
      reset     = 1'b1;
      rx        = 1'b1;  // line idle
      mcu_ready = 1'b1;
      sent_done = 1'b0;
      seed      = 32'h6488_d0c9;

      // random chip bytes of which only the low two bits stick
      // each draw has to move chip away from its previous value
      rnd_a = $random(seed);
      while (rnd_a[1:0] == 2'b00)
         rnd_a = $random(seed);
      rnd_b = $random(seed);
      while (rnd_b[1:0] == rnd_a[1:0])
         rnd_b = $random(seed);
      cmd_tbl[0] = '{cmd_set_chip, rnd_a[7:0], 1'b1, `VB_REPLY_ACK, rnd_a[1:0], 1'b1};
      cmd_tbl[1] = '{cmd_get_chip, 8'h00, 1'b0, {6'b0, rnd_a[1:0]}, rnd_a[1:0], 1'b1};
      cmd_tbl[2] = '{cmd_cpu_reset, 8'h00, 1'b1, `VB_REPLY_ACK, rnd_a[1:0], 1'b0};
      cmd_tbl[3] = '{cmd_get_version, 8'h00, 1'b0, `VB_VERSION, rnd_a[1:0], 1'b0};
      cmd_tbl[4] = '{8'h7f, 8'h00, 1'b0, `VB_REPLY_NAK, rnd_a[1:0], 1'b0};  // unknown
      cmd_tbl[5] = '{cmd_cpu_reset, 8'h01, 1'b1, `VB_REPLY_ACK, rnd_a[1:0], 1'b1};
      cmd_tbl[6] = '{cmd_set_chip, rnd_b[7:0], 1'b1, `VB_REPLY_ACK, rnd_b[1:0], 1'b1};
      cmd_tbl[7] = '{cmd_get_chip, 8'h00, 1'b0, {6'b0, rnd_b[1:0]}, rnd_b[1:0], 1'b1};
      cmd_tbl[8] = '{8'h7f, 8'h00, 1'b0, `VB_REPLY_NAK, rnd_b[1:0], 1'b1};
      cmd_tbl[9] = '{cmd_cpu_reset, 8'h00, 1'b1, `VB_REPLY_ACK, rnd_b[1:0], 1'b0};

      repeat (5) @(posedge sys_clock);
      #2;
      reset = 1'b0;

      // values right after reset
      errs_before = error_count;
      if (tx !== 1'b1) begin
         $display("[ERROR] tx: got %h expected %h", tx, 1'b1);
         error_count++;
      end
      if (chip !== 2'b00) begin
         $display("[ERROR] chip: got %h expected %h", chip, 2'b00);
         error_count++;
      end
      if (cpu_reset !== 1'b1) begin
         $display("[ERROR] cpu_reset: got %h expected %h", cpu_reset, 1'b1);
         error_count++;
      end
      if (clk_phi !== 1'b0) begin
         $display("[ERROR] clk_phi: got %h expected %h", clk_phi, 1'b0);
         error_count++;
      end
      report_test("reset values", errs_before);

      errs_before = error_count;
      check_phi();
      report_test("phi divider", errs_before);

      for (i = 0; i < NUM_CMDS; i++) begin
         errs_before = error_count;
         fork
            begin
               send_byte(cmd_tbl[i].opcode);
               if (cmd_tbl[i].has_data)
                  send_byte(cmd_tbl[i].data);
            end
            recv_byte(got, ok);  // reply starts right after the last stop bit
         join
         if (ok && got !== cmd_tbl[i].exp_reply) begin
            $display("[ERROR] tx reply: got %h expected %h", got, cmd_tbl[i].exp_reply);
            error_count++;
         end
         if (chip !== cmd_tbl[i].exp_chip) begin
            $display("[ERROR] chip: got %h expected %h", chip, cmd_tbl[i].exp_chip);
            error_count++;
         end
         if (cpu_reset !== cmd_tbl[i].exp_cpu_reset) begin
            $display("[ERROR] cpu_reset: got %h expected %h",
                     cpu_reset, cmd_tbl[i].exp_cpu_reset);
            error_count++;
         end
         report_test($sformatf("command %0d opcode %h", i, cmd_tbl[i].opcode), errs_before);
      end

      // replies pile up in the queue while the mcu is not ready
      errs_before = error_count;
      mcu_ready   = 1'b0;
      repeat (4) next_cycle();  // past the ready synchronizer
      low_cnt = 0;
      fork
         begin
            repeat (4) send_byte(cmd_get_version);
            sent_done = 1'b1;
         end
         begin
            while (!sent_done && low_cnt < START_TIMEOUT) begin
               if (tx !== 1'b1)
                  low_cnt++;
               next_cycle();
            end
         end
      join
      repeat (2 * `VB_CLKS_PER_BIT) begin  // last reply settles into the queue
         if (tx !== 1'b1)
            low_cnt++;
         next_cycle();
      end
      if (low_cnt != 0) begin
         $display("tx left idle on %0d cycles while mcu_ready was low", low_cnt);
         error_count++;
      end
      mcu_ready = 1'b1;
      repeat (4) begin
         recv_byte(got, ok);
         if (ok && got !== `VB_VERSION) begin
            $display("[ERROR] tx reply: got %h expected %h", got, `VB_VERSION);
            error_count++;
         end
      end
      low_cnt = 0;
      repeat (30 * `VB_CLKS_PER_BIT) begin  // nothing more may follow
         if (tx !== 1'b1)
            low_cnt++;
         next_cycle();
      end
      if (low_cnt != 0) begin
         $display("more than four replies came out after mcu_ready went high");
         error_count++;
      end
      report_test("back-pressure", errs_before);

      $display("tests %0d, failing tests %0d, errors %0d", test_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule : tb_vic_board_top

`default_nettype wire

// ==== vic_board_top.f ====
+incdir+common
common/vic_board_pkg.sv
serial/serial_rx.sv
serial/serial_tx.sv
design/config_ctrl.sv
design/phi_gen.sv
design/vic_board_top.sv
test/tb_vic_board_top.sv
